/* hw/cu_config.svh */
/*
 * Build-time sizes of the compute unit
 * CU_DATA_W is also the instruction width and the packed forms assume 32 bits
 * CU_ROM_LATENCY must be 1 or more
 */
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// Register and instruction word width
`define CU_DATA_W 32
// Register file size, r0 reads as zero
`define CU_NUM_REGS 16
// Instruction memory depth in words
`define CU_IMEM_DEPTH 256
// AXI byte address width
`define CU_AXI_ADDR_W 32
// Cycles from AR handshake to R valid
`define CU_ROM_LATENCY 2

// Derived index widths
`define CU_REG_AW ($clog2(`CU_NUM_REGS))
`define CU_IMEM_AW ($clog2(`CU_IMEM_DEPTH))

`endif

/* hw/cu_pkg.sv */
/*
 * Opcodes and instruction formats of the compute unit
 * Opcode values not listed here execute as no-operation
 */
`default_nettype none

`include "cu_config.svh"

package cu_pkg;

    // ####################
    // Field widths
    // ####################

    localparam int unsigned CU_OP_W  = 4;
    // Immediate fills what is left after opcode, rd and rs1
    localparam int unsigned CU_IMM_W = `CU_DATA_W - CU_OP_W - 2 * `CU_REG_AW;
    localparam int unsigned CU_PAD_W = `CU_DATA_W - CU_OP_W - 3 * `CU_REG_AW;

    // ####################
    // Opcodes
    // ####################

    typedef enum logic [CU_OP_W-1:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SHL  = 4'h5,
        // rd = rs1 + sign-extended imm
        OP_ADDI = 4'h6,
        // pc = pc + imm when rs1 is non-zero
        OP_JNZ  = 4'h7,
        OP_HALT = 4'hf
    } cu_opcode_e;

    // Register form, rd = rs1 op rs2
    typedef struct packed {
        cu_opcode_e               opcode;
        logic [`CU_REG_AW-1:0]    rd;
        logic [`CU_REG_AW-1:0]    rs1;
        logic [`CU_REG_AW-1:0]    rs2;
        logic [CU_PAD_W-1:0]      unused;
    } cu_instr_r_t;

    // Immediate form, used by ADDI and JNZ
    typedef struct packed {
        cu_opcode_e               opcode;
        logic [`CU_REG_AW-1:0]    rd;
        logic [`CU_REG_AW-1:0]    rs1;
        logic signed [CU_IMM_W-1:0] imm;
    } cu_instr_i_t;

    // One fetched word, seen through either form
    typedef union packed {
        cu_instr_r_t r;
        cu_instr_i_t i;
    } cu_instr_u;

endpackage

`default_nettype wire

/* hw/imem_to_axi.sv */
/*
 * Word-addressed instruction fetch onto the AXI read channels
 * Single-beat fixed reads only, R data is always accepted
 */
`default_nettype none

`include "cu_config.svh"

module imem_to_axi (
    // Fetch request from the control module
    input  logic                        fetch_valid_i,
    input  logic [`CU_IMEM_AW-1:0]      fetch_addr_i,
    output logic                        fetch_ready_o,
    // Fetch response back to the control module
    output logic                        fetch_rsp_valid_o,
    output logic [`CU_DATA_W-1:0]       fetch_rsp_data_o,
    // AR channel
    output logic                        ar_valid_o,
    output logic [`CU_AXI_ADDR_W-1:0]   ar_addr_o,
    output logic [2:0]                  ar_size_o,
    output logic [1:0]                  ar_burst_o,
    input  logic                        ar_ready_i,
    // R channel
    input  logic                        r_valid_i,
    input  logic [`CU_DATA_W-1:0]       r_data_i,
    output logic                        r_ready_o
);

    localparam int unsigned AXI_ADDR_W  = `CU_AXI_ADDR_W;
    // Byte offset bits within one instruction word
    localparam int unsigned BYTE_OFF_W  = $clog2(`CU_DATA_W / 8);
    localparam logic [1:0]  BURST_FIXED = 2'b00;

    // ####################
    // Request
    // ####################

    // Fetch handshake is the AR handshake
    assign fetch_ready_o = ar_ready_i;
    assign ar_valid_o    = fetch_valid_i;

    // Word address to byte address
    assign ar_addr_o  = AXI_ADDR_W'(fetch_addr_i) << BYTE_OFF_W;
    // One full word per beat
    assign ar_size_o  = 3'(BYTE_OFF_W);
    assign ar_burst_o = BURST_FIXED;

    // ####################
    // Response
    // ####################

    // No back-pressure on read data
    assign r_ready_o         = 1'b1;
    assign fetch_rsp_valid_o = r_valid_i;
    assign fetch_rsp_data_o  = r_data_i;

endmodule

`default_nettype wire

/* hw/axi_instr_rom.sv */
/*
 * AXI read-only instruction memory, one read in flight at a time
 * ar_size and ar_burst are not decoded, every read returns one word
 * The loading port must only be used while no read is pending
 */
`default_nettype none

`include "cu_config.svh"

module axi_instr_rom (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // AR channel
    input  logic                        ar_valid_i,
    input  logic [`CU_AXI_ADDR_W-1:0]   ar_addr_i,
    input  logic [2:0]                  ar_size_i,
    input  logic [1:0]                  ar_burst_i,
    output logic                        ar_ready_o,
    // R channel
    input  logic                        r_ready_i,
    output logic                        r_valid_o,
    output logic [`CU_DATA_W-1:0]       r_data_o,
    // Loading port
    input  logic                        prog_we_i,
    input  logic [`CU_IMEM_AW-1:0]      prog_addr_i,
    input  logic [`CU_DATA_W-1:0]       prog_data_i
);

    localparam int unsigned BYTE_OFF_W = $clog2(`CU_DATA_W / 8);
    localparam int unsigned CNT_W      = $clog2(`CU_ROM_LATENCY + 1);

    logic [`CU_DATA_W-1:0]  mem [`CU_IMEM_DEPTH];
    logic                   pending_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [`CU_IMEM_AW-1:0] idx_q;
    logic                   ar_hs;
    logic                   r_hs;

    // ####################
    // Handshakes
    // ####################

    // Accept a new address only when idle
    assign ar_ready_o = !pending_q;
    assign ar_hs      = ar_valid_i && ar_ready_o;

    // Data is due once the latency counter has run out
    assign r_valid_o  = pending_q && (cnt_q == '0);
    assign r_hs       = r_valid_o && r_ready_i;
    assign r_data_o   = mem[idx_q];

    // ####################
    // Read tracking
    // ####################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
            cnt_q     <= '0;
        end else if (ar_hs) begin
            pending_q <= 1'b1;
            // Counter at zero means data in the next cycle
            cnt_q     <= CNT_W'(`CU_ROM_LATENCY - 1);
        end else if (pending_q && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (r_hs) begin
            pending_q <= 1'b0;
        end
    end

    // Word index taken from the byte address
    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            idx_q <= ar_addr_i[BYTE_OFF_W +: `CU_IMEM_AW];
        end
    end

    // Program loading, one word per cycle
    always_ff @(posedge clk_i) begin
        if (prog_we_i) begin
            mem[prog_addr_i] <= prog_data_i;
        end
    end

endmodule

`default_nettype wire

/* hw/cu_ctrl.sv */
/*
 * Fetch and execute sequencing, one instruction at a time
 * start_i is only taken in IDLE and a run always begins at address 0
 * Jump targets wrap modulo the instruction memory depth
 */
`default_nettype none

`include "cu_config.svh"

module cu_ctrl (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        start_i,
    output logic                        busy_o,
    output logic                        done_o,
    // Fetch side
    output logic                        fetch_valid_o,
    output logic [`CU_IMEM_AW-1:0]      fetch_addr_o,
    input  logic                        fetch_ready_i,
    input  logic                        fetch_rsp_valid_i,
    input  logic [`CU_DATA_W-1:0]       fetch_rsp_data_i,
    // Execute side
    output logic                        exec_en_o,
    output cu_pkg::cu_opcode_e          op_o,
    output logic [`CU_REG_AW-1:0]       rd_o,
    output logic [`CU_REG_AW-1:0]       rs1_o,
    output logic [`CU_REG_AW-1:0]       rs2_o,
    output logic [`CU_DATA_W-1:0]       imm_o,
    input  logic                        rs1_zero_i
);

    import cu_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_WAIT  = 2'd2;
    localparam logic [1:0] ST_EXEC  = 2'd3;

    logic [1:0]             state_q;
    logic [`CU_IMEM_AW-1:0] pc_q;
    logic [`CU_IMEM_AW-1:0] pc_next;
    logic                   done_q;
    cu_instr_u              instr_q;

    // ####################
    // Outputs
    // ####################

    assign busy_o        = (state_q != ST_IDLE);
    assign done_o        = done_q;
    assign fetch_valid_o = (state_q == ST_FETCH);
    assign fetch_addr_o  = pc_q;
    assign exec_en_o     = (state_q == ST_EXEC);

    // ####################
    // Decode
    // ####################

    always_comb begin
        op_o  = instr_q.r.opcode;
        // rd and rs1 sit at the same bits in both forms
        rd_o  = instr_q.r.rd;
        rs1_o = instr_q.r.rs1;
        rs2_o = '0;
        imm_o = '0;
        case (instr_q.r.opcode)
            // Immediate form sign-extends imm to the data width
            OP_ADDI, OP_JNZ: begin
                imm_o = {{(`CU_DATA_W - CU_IMM_W){instr_q.i.imm[CU_IMM_W-1]}},
                         instr_q.i.imm};
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: begin
                rs2_o = instr_q.r.rs2;
            end
            // HALT and unknown codes need no operands
            default: rs2_o = '0;
        endcase
    end

    // Taken jump adds imm and wraps at the memory depth
    always_comb begin
        pc_next = pc_q + 1'b1;
        if (op_o == OP_JNZ && !rs1_zero_i) begin
            pc_next = pc_q + imm_o[`CU_IMEM_AW-1:0];
        end
    end

    // ####################
    // State machine
    // ####################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            pc_q    <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        pc_q    <= '0;
                        state_q <= ST_FETCH;
                    end
                end
                // Request stays up until the AR handshake
                ST_FETCH: begin
                    if (fetch_ready_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (fetch_rsp_valid_i) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (op_o == OP_HALT) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end else begin
                        pc_q    <= pc_next;
                        state_q <= ST_FETCH;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Fetched word held through EXEC
    always_ff @(posedge clk_i) begin
        if (state_q == ST_WAIT && fetch_rsp_valid_i) begin
            instr_q <= cu_instr_u'(fetch_rsp_data_i);
        end
    end

endmodule

`default_nettype wire

/* hw/cu_exec.sv */
/*
 * Register file and ALU, writes rd once per exec_en pulse
 * r0 is held at zero, SHL shifts by the low bits of rs2 only
 */
`default_nettype none

`include "cu_config.svh"

module cu_exec (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        exec_en_i,
    input  cu_pkg::cu_opcode_e          op_i,
    input  logic [`CU_REG_AW-1:0]       rd_i,
    input  logic [`CU_REG_AW-1:0]       rs1_i,
    input  logic [`CU_REG_AW-1:0]       rs2_i,
    input  logic [`CU_DATA_W-1:0]       imm_i,
    // Jump condition back to control
    output logic                        rs1_zero_o,
    // Debug read port
    input  logic [`CU_REG_AW-1:0]       dbg_raddr_i,
    output logic [`CU_DATA_W-1:0]       dbg_rdata_o
);

    import cu_pkg::*;

    // Shift amount bits for a full-width shift
    localparam int unsigned SHAMT_W = $clog2(`CU_DATA_W);

    logic [`CU_DATA_W-1:0] regs_q [`CU_NUM_REGS];
    logic [`CU_DATA_W-1:0] rs1_val;
    logic [`CU_DATA_W-1:0] rs2_val;
    logic [`CU_DATA_W-1:0] result;
    logic                  wr_en;

    // ####################
    // Operand read
    // ####################

    assign rs1_val     = regs_q[rs1_i];
    assign rs2_val     = regs_q[rs2_i];
    assign rs1_zero_o  = (rs1_val == '0);
    assign dbg_rdata_o = regs_q[dbg_raddr_i];

    // ####################
    // ALU
    // ####################

    always_comb begin
        result = '0;
        wr_en  = 1'b1;
        case (op_i)
            OP_ADD:  result = rs1_val + rs2_val;
            OP_SUB:  result = rs1_val - rs2_val;
            OP_AND:  result = rs1_val & rs2_val;
            OP_OR:   result = rs1_val | rs2_val;
            OP_XOR:  result = rs1_val ^ rs2_val;
            OP_SHL:  result = rs1_val << rs2_val[SHAMT_W-1:0];
            OP_ADDI: result = rs1_val + imm_i;
            // JNZ, HALT and unknown codes leave the registers alone
            default: wr_en = 1'b0;
        endcase
    end

    // ####################
    // Write-back
    // ####################

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            regs_q <= '{default: '0};
        end else if (exec_en_i && wr_en && rd_i != '0) begin
            // r0 never written so it keeps reading zero
            regs_q[rd_i] <= result;
        end
    end

endmodule

`default_nettype wire

/* hw/cu_top.sv */
/*
 * Compute unit with its AXI instruction memory
 * Load the program while busy_o is low, then pulse start_i
 * Loading writes during a run are dropped
 */
`default_nettype none

`include "cu_config.svh"

module cu_top (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        start_i,
    output logic                        busy_o,
    output logic                        done_o,
    // Loading port
    input  logic                        prog_we_i,
    input  logic [`CU_IMEM_AW-1:0]      prog_addr_i,
    input  logic [`CU_DATA_W-1:0]       prog_data_i,
    // Debug read port
    input  logic [`CU_REG_AW-1:0]       dbg_raddr_i,
    output logic [`CU_DATA_W-1:0]       dbg_rdata_o
);

    import cu_pkg::*;

    // Fetch side
    logic                       fetch_valid;
    logic [`CU_IMEM_AW-1:0]     fetch_addr;
    logic                       fetch_ready;
    logic                       fetch_rsp_valid;
    logic [`CU_DATA_W-1:0]      fetch_rsp_data;
    // AXI read channels
    logic                       ar_valid;
    logic [`CU_AXI_ADDR_W-1:0]  ar_addr;
    logic [2:0]                 ar_size;
    logic [1:0]                 ar_burst;
    logic                       ar_ready;
    logic                       r_valid;
    logic [`CU_DATA_W-1:0]      r_data;
    logic                       r_ready;
    // Execute side
    logic                       exec_en;
    cu_opcode_e                 op;
    logic [`CU_REG_AW-1:0]      rd;
    logic [`CU_REG_AW-1:0]      rs1;
    logic [`CU_REG_AW-1:0]      rs2;
    logic [`CU_DATA_W-1:0]      imm;
    logic                       rs1_zero;
    logic                       prog_we;

    // Memory is only loaded while the unit is idle
    assign prog_we = prog_we_i && !busy_o;

    cu_ctrl ctrl0 (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .start_i           (start_i),
        .busy_o            (busy_o),
        .done_o            (done_o),
        .fetch_valid_o     (fetch_valid),
        .fetch_addr_o      (fetch_addr),
        .fetch_ready_i     (fetch_ready),
        .fetch_rsp_valid_i (fetch_rsp_valid),
        .fetch_rsp_data_i  (fetch_rsp_data),
        .exec_en_o         (exec_en),
        .op_o              (op),
        .rd_o              (rd),
        .rs1_o             (rs1),
        .rs2_o             (rs2),
        .imm_o             (imm),
        .rs1_zero_i        (rs1_zero)
    );

    imem_to_axi fetch0 (
        .fetch_valid_i     (fetch_valid),
        .fetch_addr_i      (fetch_addr),
        .fetch_ready_o     (fetch_ready),
        .fetch_rsp_valid_o (fetch_rsp_valid),
        .fetch_rsp_data_o  (fetch_rsp_data),
        .ar_valid_o        (ar_valid),
        .ar_addr_o         (ar_addr),
        .ar_size_o         (ar_size),
        .ar_burst_o        (ar_burst),
        .ar_ready_i        (ar_ready),
        .r_valid_i         (r_valid),
        .r_data_i          (r_data),
        .r_ready_o         (r_ready)
    );

    axi_instr_rom rom0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ar_valid_i  (ar_valid),
        .ar_addr_i   (ar_addr),
        .ar_size_i   (ar_size),
        .ar_burst_i  (ar_burst),
        .ar_ready_o  (ar_ready),
        .r_ready_i   (r_ready),
        .r_valid_o   (r_valid),
        .r_data_o    (r_data),
        .prog_we_i   (prog_we),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i)
    );

    cu_exec exec0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .exec_en_i   (exec_en),
        .op_i        (op),
        .rd_i        (rd),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .imm_i       (imm),
        .rs1_zero_o  (rs1_zero),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

endmodule

`default_nettype wire

/* verif/cu_asserts.sv */
/*
 * Protocol checks on the compute unit, bound into cu_top
 * Assumes r_ready stays high, so every r_valid ends the read in flight
 */
`default_nettype none

`include "cu_config.svh"

module cu_asserts (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        ar_valid_i,
    input  logic                        ar_ready_i,
    input  logic [`CU_AXI_ADDR_W-1:0]   ar_addr_i,
    input  logic                        r_valid_i,
    input  logic                        prog_we_i,
    input  logic                        busy_i,
    input  logic                        done_i
);

    timeunit 1ns;
    timeprecision 100ps;

    logic pending_q;

    // Own view of the read in flight
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else if (ar_valid_i && ar_ready_i) begin
            pending_q <= 1'b1;
        end else if (r_valid_i) begin
            pending_q <= 1'b0;
        end
    end

    // ####################
    // AXI read channels
    // ####################

    ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else $error("AR request dropped or changed before ar_ready");

    r_after_ar: assert property (@(posedge clk_i) disable iff (reset_i)
        r_valid_i |-> pending_q)
        else $error("r_valid without a pending read");

    // Word-aligned fetches only
    ar_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        ar_valid_i |-> ar_addr_i[1:0] == 2'b00)
        else $error("ar_addr not word aligned");

    // ####################
    // Control
    // ####################

    load_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        prog_we_i |-> !busy_i)
        else $error("prog_we_i high while the unit is busy");

    done_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        done_i |=> !done_i)
        else $error("done_o high for more than one cycle");

endmodule

bind cu_top cu_asserts asserts0 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ar_valid_i (ar_valid),
    .ar_ready_i (ar_ready),
    .ar_addr_i  (ar_addr),
    .r_valid_i  (r_valid),
    .prog_we_i  (prog_we_i),
    .busy_i     (busy_o),
    .done_i     (done_o)
);

`default_nettype wire

/* verif/cu_tb.sv */
/*
 * Testbench for cu_top, results checked against a behavioral model
 * Registers carry over between programs, so the model state does too
 * Protocol assertions come in through the bound cu_asserts module
 */
`default_nettype none

`include "cu_config.svh"

module cu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import cu_pkg::*;

    localparam int DATA_W       = `CU_DATA_W;
    localparam int NUM_REGS     = `CU_NUM_REGS;
    localparam int REG_AW       = `CU_REG_AW;
    localparam int IMEM_AW      = `CU_IMEM_AW;
    localparam int IMEM_DEPTH   = `CU_IMEM_DEPTH;
    localparam int LATENCY      = `CU_ROM_LATENCY;
    localparam int SHAMT_W      = $clog2(DATA_W);
    localparam int NUM_TESTS    = 4;
    localparam int MAX_WORDS    = 16;
    localparam int RESET_CYCLES = 10;
    // Start, restart try, done wait and register sweep per program
    localparam int TEST_CYCLES  = 40;
    localparam int MARGIN       = 200;
    localparam int MODEL_MAX    = 1000;

    logic                  clk_i;
    logic                  reset_i;
    logic                  start_i;
    logic                  busy_o;
    logic                  done_o;
    logic                  prog_we_i;
    logic [IMEM_AW-1:0]    prog_addr_i;
    logic [DATA_W-1:0]     prog_data_i;
    logic [REG_AW-1:0]     dbg_raddr_i;
    logic [DATA_W-1:0]     dbg_rdata_o;

    // Program table and expected register files
    string                 test_name   [NUM_TESTS];
    logic [DATA_W-1:0]     prog_mem    [NUM_TESTS][MAX_WORDS];
    int                    prog_len    [NUM_TESTS];
    int                    key_reg     [NUM_TESTS];
    bit                    restart_try [NUM_TESTS];
    logic [DATA_W-1:0]     exp_regs    [NUM_TESTS][NUM_REGS];
    // Model state
    logic [DATA_W-1:0]     model_mem   [IMEM_DEPTH];
    logic [DATA_W-1:0]     model_regs  [NUM_REGS];
    int                    cycle_count = 0;
    int                    cycle_limit = 0;
    int                    checks_done = 0;
    int                    done_count  = 0;

    cu_top dut0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    // Counted mid-cycle, away from the edge where done_o moves
    always @(negedge clk_i) begin
        if (done_o === 1'b1) begin
            done_count = done_count + 1;
        end
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles", cycle_limit));
        end
    end

    // ####################
    // Helpers
    // ####################

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    // Next rising edge plus the drive delay
    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_value(input string label, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        checks_done = checks_done + 1;
        assert (actual === expected) else begin
            stop_with_failure($sformatf("ERROR %s expected %h actual %h",
                                        label, expected, actual));
        end
    endtask

    task automatic read_reg(input int r, output logic [DATA_W-1:0] val);
        dbg_raddr_i = REG_AW'(r);
        step();
        val = dbg_rdata_o;
    endtask

    function automatic logic [DATA_W-1:0] reg_word(cu_opcode_e op, int rd, int rs1, int rs2);
        cu_instr_u u;
        u          = '0;
        u.r.opcode = op;
        u.r.rd     = REG_AW'(rd);
        u.r.rs1    = REG_AW'(rs1);
        u.r.rs2    = REG_AW'(rs2);
        return u;
    endfunction

    function automatic logic [DATA_W-1:0] imm_word(cu_opcode_e op, int rd, int rs1, int imm);
        cu_instr_u u;
        u          = '0;
        u.i.opcode = op;
        u.i.rd     = REG_AW'(rd);
        u.i.rs1    = REG_AW'(rs1);
        u.i.imm    = CU_IMM_W'(imm);
        return u;
    endfunction

    // Random value in the signed immediate range
    function automatic int rand_imm();
        logic [DATA_W-1:0] r;
        r = $urandom;
        return int'($signed(r[CU_IMM_W-1:0]));
    endfunction

    task automatic add_word(input int t, input logic [DATA_W-1:0] word);
        prog_mem[t][prog_len[t]] = word;
        prog_len[t] = prog_len[t] + 1;
    endtask

    // ####################
    // Program table
    // ####################

    task automatic build_programs();
        int t;
        for (t = 0; t < NUM_TESTS; t++) begin
            prog_len[t]    = 0;
            restart_try[t] = 1'b0;
        end
        // Register ALU ops on two random operands
        test_name[0] = "alu_ops";
        key_reg[0]   = 8;
        add_word(0, imm_word(OP_ADDI, 1, 0, rand_imm()));
        add_word(0, imm_word(OP_ADDI, 2, 0, rand_imm()));
        add_word(0, reg_word(OP_ADD, 3, 1, 2));
        add_word(0, reg_word(OP_SUB, 4, 1, 2));
        add_word(0, reg_word(OP_AND, 5, 1, 2));
        add_word(0, reg_word(OP_OR, 6, 1, 2));
        add_word(0, reg_word(OP_XOR, 7, 1, 2));
        add_word(0, reg_word(OP_SHL, 8, 1, 2));
        add_word(0, reg_word(OP_HALT, 0, 0, 0));
        // r0 as destination, negative immediates
        test_name[1] = "r0_and_sign";
        key_reg[1]   = 10;
        add_word(1, imm_word(OP_ADDI, 0, 0, 123));
        add_word(1, reg_word(OP_ADD, 0, 1, 2));
        add_word(1, imm_word(OP_ADDI, 9, 0, -7));
        add_word(1, imm_word(OP_ADDI, 10, 9, -1 - int'($urandom_range(65535, 0))));
        add_word(1, reg_word(OP_ADD, 11, 0, 9));
        add_word(1, reg_word(OP_HALT, 0, 0, 0));
        // Countdown loop with a backward JNZ, then a forward skip
        test_name[2] = "jnz_loop";
        key_reg[2]   = 2;
        add_word(2, imm_word(OP_ADDI, 1, 0, 6));
        add_word(2, imm_word(OP_ADDI, 2, 0, 0));
        add_word(2, reg_word(OP_ADD, 2, 2, 1));
        add_word(2, imm_word(OP_ADDI, 1, 1, -1));
        add_word(2, imm_word(OP_JNZ, 0, 1, -2));
        add_word(2, imm_word(OP_JNZ, 0, 2, 2));
        add_word(2, imm_word(OP_ADDI, 12, 0, 99));
        add_word(2, reg_word(OP_HALT, 0, 0, 0));
        // Shorter reload; a restart would bump r1 twice
        test_name[3]   = "reload";
        key_reg[3]     = 2;
        restart_try[3] = 1'b1;
        add_word(3, imm_word(OP_ADDI, 3, 0, rand_imm()));
        add_word(3, reg_word(OP_ADD, 2, 3, 3));
        add_word(3, imm_word(OP_ADDI, 1, 1, 1));
        add_word(3, reg_word(OP_HALT, 0, 0, 0));
    endtask

    // ####################
    // Reference model
    // ####################

    task automatic run_model(input int t, output int steps);
        cu_instr_u          w;
        logic [IMEM_AW-1:0] pc;
        logic [IMEM_AW-1:0] next_pc;
        logic [DATA_W-1:0]  a;
        logic [DATA_W-1:0]  b;
        logic [DATA_W-1:0]  imm;
        logic [DATA_W-1:0]  res;
        bit                 wr;
        bit                 halted;
        int                 k;
        for (k = 0; k < prog_len[t]; k++) begin
            model_mem[k] = prog_mem[t][k];
        end
        pc     = '0;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < MODEL_MAX) begin
            w       = model_mem[pc];
            // rd and rs1 sit at the same bits in both forms
            a       = model_regs[w.r.rs1];
            b       = model_regs[w.r.rs2];
            imm     = DATA_W'($signed(w.i.imm));
            res     = '0;
            wr      = 1'b1;
            next_pc = pc + IMEM_AW'(1);
            steps   = steps + 1;
            case (w.r.opcode)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_SHL:  res = a << b[SHAMT_W-1:0];
                OP_ADDI: res = a + imm;
                OP_JNZ: begin
                    wr = 1'b0;
                    if (a != '0) begin
                        next_pc = pc + imm[IMEM_AW-1:0];
                    end
                end
                OP_HALT: begin
                    wr     = 1'b0;
                    halted = 1'b1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w.r.rd != '0) begin
                model_regs[w.r.rd] = res;
            end
            pc = next_pc;
        end
    endtask

    // ####################
    // Test flow
    // ####################

    task automatic run_program(input int t);
        logic [DATA_W-1:0] val;
        int                k;
        int                r;
        for (k = 0; k < prog_len[t]; k++) begin
            prog_we_i   = 1'b1;
            prog_addr_i = IMEM_AW'(k);
            prog_data_i = prog_mem[t][k];
            step();
        end
        prog_we_i  = 1'b0;
        done_count = 0;
        start_i    = 1'b1;
        step();
        start_i    = 1'b0;
        if (restart_try[t]) begin
            repeat (3) step();
            assert (busy_o === 1'b1) else begin
                stop_with_failure($sformatf("%s not busy during its run", test_name[t]));
            end
            start_i = 1'b1;
            step();
            start_i = 1'b0;
        end
        while (done_o !== 1'b1) begin
            step();
        end
        assert (busy_o === 1'b0) else begin
            stop_with_failure($sformatf("busy_o still high at done_o in %s", test_name[t]));
        end
        repeat (2) step();
        assert (done_count == 1) else begin
            stop_with_failure($sformatf("%s gave %0d done pulses instead of one",
                                        test_name[t], done_count));
        end
        read_reg(key_reg[t], val);
        check_value($sformatf("%s key r%0d", test_name[t], key_reg[t]),
                    exp_regs[t][key_reg[t]], val);
        // Full sweep also covers r0 and untouched registers
        for (r = 0; r < NUM_REGS; r++) begin
            read_reg(r, val);
            check_value($sformatf("%s r%0d", test_name[t], r), exp_regs[t][r], val);
        end
    endtask

    initial begin
        int t;
        int steps;
        int total_steps;
        int total_words;
        void'($urandom(32'hbbc46309));
        reset_i     = 1'b1;
        start_i     = 1'b0;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        dbg_raddr_i = '0;
        build_programs();
        // Expected register files, in run order from the reset state
        model_regs  = '{default: '0};
        total_steps = 0;
        total_words = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            run_model(t, steps);
            exp_regs[t] = model_regs;
            total_steps = total_steps + steps;
            total_words = total_words + prog_len[t];
        end
        cycle_limit = total_steps * (2 + LATENCY) + total_words + RESET_CYCLES
                      + NUM_TESTS * TEST_CYCLES + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        assert (busy_o === 1'b0) else begin
            stop_with_failure("busy_o high after reset");
        end
        for (t = 0; t < NUM_TESTS; t++) begin
            run_program(t);
        end
        if (checks_done > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_failure("No register checks were run");
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+hw
hw/cu_pkg.sv
hw/imem_to_axi.sv
hw/axi_instr_rom.sv
hw/cu_ctrl.sv
hw/cu_exec.sv
hw/cu_top.sv
verif/cu_asserts.sv
verif/cu_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the compute unit testbench with Verilator.
# Exit status is the simulator's: non-zero on any failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module cu_tb \
    -o cu_tb_sim

./obj_dir/cu_tb_sim
